//--- verilog/raster_macros.svh
`ifndef RASTER_MACROS_SVH
`define RASTER_MACROS_SVH

// Viewport size in pixels.
`define RASTER_VIEWPORT_W 64
`define RASTER_VIEWPORT_H 64

// Width of one pixel coordinate, enough for 0 to 63.
`define RASTER_COORD_W 6

// Width of depth values and depth gradients.
`define RASTER_DEPTH_W 16

// Width of the triangle tag.
`define RASTER_TAG_W 8

`endif

//--- verilog/geom_pkg.sv
`include "raster_macros.svh"

package geom_pkg;

    // Vertices are whole pixels and may lie outside the viewport.
    typedef struct packed {
        logic [7:0] x;
        logic [7:0] y;
    } vertex_t;

    // Depth plane: z0 is the depth at a reference pixel, the steps are per pixel.
    typedef struct packed {
        logic signed [`RASTER_DEPTH_W-1:0] z0;
        logic signed [`RASTER_DEPTH_W-1:0] dzdx;
        logic signed [`RASTER_DEPTH_W-1:0] dzdy;
    } depth_plane_t;

    // One edge function a*X + b*Y + c, evaluated on doubled coordinates.
    typedef struct packed {
        logic signed [19:0] a;
        logic signed [19:0] b;
        logic signed [19:0] c;
    } edge_coef_t;

    // Bounding box, already clamped to the viewport.
    typedef struct packed {
        logic [`RASTER_COORD_W-1:0] left;
        logic [`RASTER_COORD_W-1:0] top;
        logic [`RASTER_COORD_W-1:0] right;
        logic [`RASTER_COORD_W-1:0] bottom;
    } bbox_t;

endpackage

//--- verilog/frag_pkg.sv
`include "raster_macros.svh"

package frag_pkg;

    typedef struct packed {
        logic [`RASTER_COORD_W-1:0] x;
        logic [`RASTER_COORD_W-1:0] y;
    } pixel_t;

    // One output fragment. The last flag marks the final pixel of a triangle.
    typedef struct packed {
        pixel_t                     pixel;
        logic                       covered;
        logic [`RASTER_DEPTH_W-1:0] depth;
        logic [`RASTER_TAG_W-1:0]   tag;
        logic                       last;
    } fragment_t;

endpackage

//--- verilog/triangle_setup.sv
`timescale 1ns/1ps
`include "raster_macros.svh"

module triangle_setup
    import geom_pkg::*;
(
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     tri_valid,
    output logic                     tri_ready,
    input  vertex_t                  tri_v0,
    input  vertex_t                  tri_v1,
    input  vertex_t                  tri_v2,
    input  depth_plane_t             tri_plane,
    input  logic [`RASTER_TAG_W-1:0] tri_tag,
    output logic                     setup_valid,
    input  logic                     setup_take,
    output edge_coef_t               edge0,
    output edge_coef_t               edge1,
    output edge_coef_t               edge2,
    output bbox_t                    bbox,
    output depth_plane_t             plane,
    output logic [`RASTER_TAG_W-1:0] tag
);

    localparam logic [7:0] MAX_X = 8'(`RASTER_VIEWPORT_W - 1);
    localparam logic [7:0] MAX_Y = 8'(`RASTER_VIEWPORT_H - 1);

    logic signed [8:0]          dx1;
    logic signed [8:0]          dy1;
    logic signed [8:0]          dx2;
    logic signed [8:0]          dy2;
    logic signed [19:0]         area2;
    logic                       accept;
    logic                       held;
    logic                       zero_area;
    logic                       swap;
    vertex_t                    pend_v0;
    vertex_t                    pend_v1;
    vertex_t                    pend_v2;
    depth_plane_t               pend_plane;
    logic [`RASTER_TAG_W-1:0]   pend_tag;
    vertex_t                    vb;
    vertex_t                    vc;
    logic [`RASTER_DEPTH_W-1:0] z_org;

    function automatic logic [7:0] min3(logic [7:0] a, logic [7:0] b, logic [7:0] c);
        logic [7:0] m;
        m = (a < b) ? a : b;
        return (m < c) ? m : c;
    endfunction

    function automatic logic [7:0] max3(logic [7:0] a, logic [7:0] b, logic [7:0] c);
        logic [7:0] m;
        m = (a > b) ? a : b;
        return (m > c) ? m : c;
    endfunction

    function automatic logic [`RASTER_COORD_W-1:0] clamp_coord(logic [7:0] v,
                                                               logic [7:0] limit);
        return (v > limit) ? limit[`RASTER_COORD_W-1:0] : v[`RASTER_COORD_W-1:0];
    endfunction

    // Edge from vi to vj. The value is zero on the edge and grows to its left.
    // Coordinates are doubled so that pixel centres are odd integers.
    function automatic edge_coef_t make_edge(vertex_t vi, vertex_t vj);
        logic signed [19:0] xi, yi, xj, yj;
        edge_coef_t e;
        xi = {12'd0, vi.x};
        yi = {12'd0, vi.y};
        xj = {12'd0, vj.x};
        yj = {12'd0, vj.y};
        e.a = yi - yj;
        e.b = xj - xi;
        e.c = (xi * yj - xj * yi) * 20'sd2;
        return e;
    endfunction

    // Twice the signed area of the incoming triangle.
    always_comb begin
        dx1 = $signed({1'b0, tri_v1.x}) - $signed({1'b0, tri_v0.x});
        dy1 = $signed({1'b0, tri_v1.y}) - $signed({1'b0, tri_v0.y});
        dx2 = $signed({1'b0, tri_v2.x}) - $signed({1'b0, tri_v0.x});
        dy2 = $signed({1'b0, tri_v2.y}) - $signed({1'b0, tri_v0.y});
        area2 = dx1 * dy2 - dy1 * dx2;
    end

    assign tri_ready   = !held;
    assign accept      = tri_valid && tri_ready;
    // A zero-area triangle is held for one cycle and never offered to the scanner.
    assign setup_valid = held && !zero_area;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            held      <= 1'b0;
            zero_area <= 1'b0;
        end else if (accept) begin
            held      <= 1'b1;
            zero_area <= (area2 == 20'sd0);
        end else if (setup_take || zero_area) begin
            held      <= 1'b0;
            zero_area <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pend_v0     <= tri_v0;
            pend_v1     <= tri_v1;
            pend_v2     <= tri_v2;
            pend_plane  <= tri_plane;
            pend_tag    <= tri_tag;
            swap        <= (area2 < 20'sd0);
            bbox.left   <= clamp_coord(min3(tri_v0.x, tri_v1.x, tri_v2.x), MAX_X);
            bbox.top    <= clamp_coord(min3(tri_v0.y, tri_v1.y, tri_v2.y), MAX_Y);
            bbox.right  <= clamp_coord(max3(tri_v0.x, tri_v1.x, tri_v2.x), MAX_X);
            bbox.bottom <= clamp_coord(max3(tri_v0.y, tri_v1.y, tri_v2.y), MAX_Y);
        end
    end

    // Negative area means the other winding, so two vertices swap places.
    assign vb = swap ? pend_v2 : pend_v1;
    assign vc = swap ? pend_v1 : pend_v2;

    // Depth at the top-left corner of the box, wrapping at the depth width.
    assign z_org = pend_plane.z0 + pend_plane.dzdx * bbox.left
                 + pend_plane.dzdy * bbox.top;

    // The working copy changes only when the scanner starts a new box, so
    // pixels still in flight keep the coefficients of their own triangle.
    always_ff @(posedge clk) begin
        if (setup_take) begin
            edge0 <= make_edge(pend_v0, vb);
            edge1 <= make_edge(vb, vc);
            edge2 <= make_edge(vc, pend_v0);
            plane <= '{z0: z_org, dzdx: pend_plane.dzdx, dzdy: pend_plane.dzdy};
            tag   <= pend_tag;
        end
    end

endmodule

//--- verilog/bbox_scanner.sv
`timescale 1ns/1ps

module bbox_scanner
    import geom_pkg::*;
    import frag_pkg::*;
(
    input  logic   clk,
    input  logic   rstn,
    input  logic   setup_valid,
    output logic   setup_take,
    input  bbox_t  bbox,
    input  logic   advance,
    output logic   scan_valid,
    output logic   scan_first,
    output logic   scan_row,
    output logic   scan_last,
    output pixel_t scan_pixel
);

    typedef enum logic {
        IDLE,
        RUN
    } scan_state_t;

    scan_state_t state;
    bbox_t       box;
    pixel_t      cur;
    logic        end_x;
    logic        end_y;
    logic        step;

    // A box is taken whenever the scanner is idle and a triangle is waiting.
    assign setup_take = (state == IDLE) && setup_valid;

    assign scan_valid = (state == RUN);
    assign scan_pixel = cur;

    assign end_x = (cur.x == box.right);
    assign end_y = (cur.y == box.bottom);
    assign step  = scan_valid && advance;

    assign scan_last  = scan_valid && end_x && end_y;
    assign scan_first = scan_valid && (cur.x == box.left) && (cur.y == box.top);
    // Every later return to the left edge begins a new row.
    assign scan_row   = scan_valid && !scan_first && (cur.x == box.left);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (setup_valid) begin
                        state <= RUN;
                    end
                end
                RUN: begin
                    // The last pixel leaves, and the next box can be taken next cycle.
                    if (step && scan_last) begin
                        state <= IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (setup_take) begin
            box <= bbox;
            cur <= '{x: bbox.left, y: bbox.top};
        end else if (step && !scan_last) begin
            if (end_x) begin
                cur.x <= box.left;
                cur.y <= cur.y + 1'b1;
            end else begin
                cur.x <= cur.x + 1'b1;
            end
        end
    end

endmodule

//--- verilog/edge_tester.sv
`timescale 1ns/1ps
`include "raster_macros.svh"

module edge_tester
    import geom_pkg::*;
    import frag_pkg::*;
(
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     advance,
    input  logic                     scan_valid,
    input  pixel_t                   scan_pixel,
    input  logic                     scan_last,
    input  edge_coef_t               edge0,
    input  edge_coef_t               edge1,
    input  edge_coef_t               edge2,
    input  logic [`RASTER_TAG_W-1:0] tag,
    output logic                     ev_valid,
    output pixel_t                   ev_pixel,
    output logic                     ev_last,
    output logic                     ev_covered,
    output logic [`RASTER_TAG_W-1:0] ev_tag
);

    logic signed [21:0] e0;
    logic signed [21:0] e1;
    logic signed [21:0] e2;

    // The pixel centre (x + 0.5, y + 0.5) is (2x + 1, 2y + 1) when doubled.
    function automatic logic signed [21:0] edge_eval(edge_coef_t e, pixel_t p);
        logic signed [7:0] sx;
        logic signed [7:0] sy;
        sx = {1'b0, p.x, 1'b1};
        sy = {1'b0, p.y, 1'b1};
        return $signed(e.a) * sx + $signed(e.b) * sy + $signed(e.c);
    endfunction

    assign e0 = edge_eval(edge0, scan_pixel);
    assign e1 = edge_eval(edge1, scan_pixel);
    assign e2 = edge_eval(edge2, scan_pixel);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ev_valid <= 1'b0;
        end else if (advance) begin
            ev_valid <= scan_valid;
        end
    end

    // A pixel on an edge counts as covered.
    always_ff @(posedge clk) begin
        if (advance && scan_valid) begin
            ev_pixel   <= scan_pixel;
            ev_last    <= scan_last;
            ev_covered <= (e0 >= 22'sd0) && (e1 >= 22'sd0) && (e2 >= 22'sd0);
            ev_tag     <= tag;
        end
    end

endmodule

//--- verilog/depth_interp.sv
`timescale 1ns/1ps
`include "raster_macros.svh"

module depth_interp
    import geom_pkg::*;
(
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       advance,
    input  logic                       scan_valid,
    input  logic                       scan_first,
    input  logic                       scan_row,
    input  depth_plane_t               plane,
    output logic [`RASTER_DEPTH_W-1:0] depth
);

    // Depth at the start of the current row.
    logic [`RASTER_DEPTH_W-1:0] row_z;
    logic [`RASTER_DEPTH_W-1:0] next_row_z;

    assign next_row_z = row_z + plane.dzdy;

    // plane.z0 already holds the depth at the top-left corner of the box.
    // The register stays in step with edge_tester, so it always holds the
    // depth of the pixel that edge_tester is presenting.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            row_z <= '0;
            depth <= '0;
        end else if (advance && scan_valid) begin
            if (scan_first) begin
                row_z <= plane.z0;
                depth <= plane.z0;
            end else if (scan_row) begin
                row_z <= next_row_z;
                depth <= next_row_z;
            end else begin
                depth <= depth + plane.dzdx;
            end
        end
    end

endmodule

//--- verilog/fragment_merge.sv
`timescale 1ns/1ps
`include "raster_macros.svh"

module fragment_merge
    import frag_pkg::*;
(
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       ev_valid,
    input  pixel_t                     ev_pixel,
    input  logic                       ev_last,
    input  logic                       ev_covered,
    input  logic [`RASTER_TAG_W-1:0]   ev_tag,
    input  logic [`RASTER_DEPTH_W-1:0] depth,
    output logic                       advance,
    input  logic                       frag_ready,
    output logic                       frag_valid,
    output fragment_t                  frag
);

    // The whole pipeline moves when the output slot is free or being emptied.
    assign advance = !frag_valid || frag_ready;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            frag_valid <= 1'b0;
        end else if (advance) begin
            frag_valid <= ev_valid;
        end
    end

    // Coverage and depth arrive in the same cycle, one stage after the scanner.
    always_ff @(posedge clk) begin
        if (advance && ev_valid) begin
            frag <= '{
                pixel:   ev_pixel,
                covered: ev_covered,
                depth:   depth,
                tag:     ev_tag,
                last:    ev_last
            };
        end
    end

endmodule

//--- verilog/rasterizer.sv
`timescale 1ns/1ps
`include "raster_macros.svh"

module rasterizer
    import geom_pkg::*;
    import frag_pkg::*;
(
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     tri_valid,
    output logic                     tri_ready,
    input  vertex_t                  tri_v0,
    input  vertex_t                  tri_v1,
    input  vertex_t                  tri_v2,
    input  depth_plane_t             tri_plane,
    input  logic [`RASTER_TAG_W-1:0] tri_tag,
    output logic                     frag_valid,
    input  logic                     frag_ready,
    output fragment_t                frag
);

    logic                       setup_valid;
    logic                       setup_take;
    edge_coef_t                 edge0;
    edge_coef_t                 edge1;
    edge_coef_t                 edge2;
    bbox_t                      bbox;
    depth_plane_t               plane;
    logic [`RASTER_TAG_W-1:0]   tag;
    logic                       advance;
    logic                       scan_valid;
    logic                       scan_first;
    logic                       scan_row;
    logic                       scan_last;
    pixel_t                     scan_pixel;
    logic                       ev_valid;
    pixel_t                     ev_pixel;
    logic                       ev_last;
    logic                       ev_covered;
    logic [`RASTER_TAG_W-1:0]   ev_tag;
    logic [`RASTER_DEPTH_W-1:0] depth;

    triangle_setup i_triangle_setup (
        .clk         (clk),
        .rstn        (rstn),
        .tri_valid   (tri_valid),
        .tri_ready   (tri_ready),
        .tri_v0      (tri_v0),
        .tri_v1      (tri_v1),
        .tri_v2      (tri_v2),
        .tri_plane   (tri_plane),
        .tri_tag     (tri_tag),
        .setup_valid (setup_valid),
        .setup_take  (setup_take),
        .edge0       (edge0),
        .edge1       (edge1),
        .edge2       (edge2),
        .bbox        (bbox),
        .plane       (plane),
        .tag         (tag)
    );

    bbox_scanner i_bbox_scanner (
        .clk         (clk),
        .rstn        (rstn),
        .setup_valid (setup_valid),
        .setup_take  (setup_take),
        .bbox        (bbox),
        .advance     (advance),
        .scan_valid  (scan_valid),
        .scan_first  (scan_first),
        .scan_row    (scan_row),
        .scan_last   (scan_last),
        .scan_pixel  (scan_pixel)
    );

    // Coverage and depth are worked out side by side for the same pixel.
    edge_tester i_edge_tester (
        .clk         (clk),
        .rstn        (rstn),
        .advance     (advance),
        .scan_valid  (scan_valid),
        .scan_pixel  (scan_pixel),
        .scan_last   (scan_last),
        .edge0       (edge0),
        .edge1       (edge1),
        .edge2       (edge2),
        .tag         (tag),
        .ev_valid    (ev_valid),
        .ev_pixel    (ev_pixel),
        .ev_last     (ev_last),
        .ev_covered  (ev_covered),
        .ev_tag      (ev_tag)
    );

    depth_interp i_depth_interp (
        .clk         (clk),
        .rstn        (rstn),
        .advance     (advance),
        .scan_valid  (scan_valid),
        .scan_first  (scan_first),
        .scan_row    (scan_row),
        .plane       (plane),
        .depth       (depth)
    );

    fragment_merge i_fragment_merge (
        .clk         (clk),
        .rstn        (rstn),
        .ev_valid    (ev_valid),
        .ev_pixel    (ev_pixel),
        .ev_last     (ev_last),
        .ev_covered  (ev_covered),
        .ev_tag      (ev_tag),
        .depth       (depth),
        .advance     (advance),
        .frag_ready  (frag_ready),
        .frag_valid  (frag_valid),
        .frag        (frag)
    );

endmodule

//--- tb/rasterizer_checker.sv
`timescale 1ns/1ps

module rasterizer_checker
    import frag_pkg::*;
(
    input logic      clk,
    input logic      rstn,
    input logic      frag_valid,
    input logic      frag_ready,
    input fragment_t frag
);

    // The output register is empty in reset and in the first cycle after it.
    reset_empty: assert property (@(posedge clk) !rstn |=> !frag_valid)
        else $error("frag_valid is high in or right after reset");

    // A stalled fragment waits unchanged until the sink takes it.
    stall_stable: assert property (@(posedge clk) disable iff (!rstn)
        frag_valid && !frag_ready |=> frag_valid && $stable(frag))
        else $error("frag changed or dropped while stalled");

    known_frag: assert property (@(posedge clk) disable iff (!rstn)
        frag_valid |-> !$isunknown(frag))
        else $error("frag holds unknown bits while frag_valid is high");

endmodule

bind rasterizer rasterizer_checker i_rasterizer_checker (
    .clk        (clk),
    .rstn       (rstn),
    .frag_valid (frag_valid),
    .frag_ready (frag_ready),
    .frag       (frag)
);

//--- tb/rasterizer_tb.sv
`timescale 1ns/1ps
`include "raster_macros.svh"

module rasterizer_tb
    import geom_pkg::*;
    import frag_pkg::*;
();

    localparam int NUM_TRI       = 10;
    localparam int MARGIN_CYCLES = 400;
    localparam int MAX_COORD     = `RASTER_VIEWPORT_W - 1;

    logic                     clk = 1'b0;
    logic                     rstn;
    logic                     tri_valid;
    logic                     tri_ready;
    vertex_t                  tri_v0;
    vertex_t                  tri_v1;
    vertex_t                  tri_v2;
    depth_plane_t             tri_plane;
    logic [`RASTER_TAG_W-1:0] tri_tag;
    logic                     frag_valid;
    logic                     frag_ready;
    fragment_t                frag;

    // Triangle table, one row per test.
    string                    name_tab  [NUM_TRI];
    vertex_t                  v0_tab    [NUM_TRI];
    vertex_t                  v1_tab    [NUM_TRI];
    vertex_t                  v2_tab    [NUM_TRI];
    depth_plane_t             plane_tab [NUM_TRI];
    logic [`RASTER_TAG_W-1:0] tag_tab   [NUM_TRI];

    fragment_t exp_q[$];
    int        exp_idx_q[$];
    int        errors;
    int        received;
    int        total_pixels;
    bit        model_done;

    rasterizer i_rasterizer (
        .clk        (clk),
        .rstn       (rstn),
        .tri_valid  (tri_valid),
        .tri_ready  (tri_ready),
        .tri_v0     (tri_v0),
        .tri_v1     (tri_v1),
        .tri_v2     (tri_v2),
        .tri_plane  (tri_plane),
        .tri_tag    (tri_tag),
        .frag_valid (frag_valid),
        .frag_ready (frag_ready),
        .frag       (frag)
    );

    always #2 clk = ~clk;

    task automatic set_entry(input int idx, input string name,
                             input int ax, input int ay, input int bx, input int by,
                             input int cx, input int cy, input logic [15:0] z0,
                             input logic [15:0] dzdx, input logic [15:0] dzdy,
                             input logic [7:0] tg);
        name_tab[idx]  = name;
        v0_tab[idx]    = '{x: 8'(ax), y: 8'(ay)};
        v1_tab[idx]    = '{x: 8'(bx), y: 8'(by)};
        v2_tab[idx]    = '{x: 8'(cx), y: 8'(cy)};
        plane_tab[idx] = '{z0: z0, dzdx: dzdx, dzdy: dzdy};
        tag_tab[idx]   = tg;
    endtask

    task automatic fill_table();
        set_entry(0, "winding_pos", 10, 10, 20, 12, 12, 22, 16'h1000, 16'h0010, 16'h0100, 8'h11);
        set_entry(1, "winding_neg", 30, 5, 34, 16, 40, 6, 16'h8000, 16'hfff8, 16'h0003, 8'h22);
        set_entry(2, "clamp_corner", 50, 40, 90, 45, 55, 70, 16'hfff0, 16'h0101, 16'hff00, 8'h33);
        set_entry(3, "clamp_tall", 60, 0, 120, 3, 62, 200, 16'h0000, 16'h7fff, 16'h0001, 8'h44);
        set_entry(4, "zero_area", 5, 5, 10, 10, 15, 15, 16'h0100, 16'h0001, 16'h0001, 8'h55);
        set_entry(5, "after_zero", 2, 30, 8, 30, 2, 36, 16'h0040, 16'h0002, 16'hfffe, 8'h66);
        set_entry(6, "back_to_back_a", 0, 0, 5, 0, 0, 5, 16'h1234, 16'h0001, 16'h0040, 8'ha1);
        set_entry(7, "back_to_back_b", 3, 50, 9, 58, 1, 57, 16'habcd, 16'hfff0, 16'h0020, 8'hb2);
        set_entry(8, "single_pixel", 63, 63, 100, 63, 63, 100, 16'h0777, 16'h0100, 16'h0200,
                  8'hc3);
        set_entry(9, "thin_sliver", 20, 20, 40, 23, 21, 22, 16'h0500, 16'h0008, 16'h0030, 8'hd4);
    endtask

    function automatic int min_of3(int a, int b, int c);
        int m;
        m = (a < b) ? a : b;
        return (m < c) ? m : c;
    endfunction

    function automatic int max_of3(int a, int b, int c);
        int m;
        m = (a > b) ? a : b;
        return (m > c) ? m : c;
    endfunction

    function automatic int clamp_to_view(int v);
        return (v > MAX_COORD) ? MAX_COORD : v;
    endfunction

    // Cross product of (j - i) and (p - i), all in doubled coordinates.
    function automatic int side_of_edge(int xi, int yi, int xj, int yj, int px, int py);
        return (xj - xi) * (py - yi) - (yj - yi) * (px - xi);
    endfunction

    // Reference model: the clamped box in row order, with coverage tested at
    // pixel centres and the depth plane evaluated directly at each pixel.
    task automatic add_expected(input int idx);
        int        ax, ay, bx, by, cx, cy;
        int        area, left, right, top, bottom;
        int        x, y, px, py, w0, w1, w2, zi;
        fragment_t f;
        ax = v0_tab[idx].x;
        ay = v0_tab[idx].y;
        bx = v1_tab[idx].x;
        by = v1_tab[idx].y;
        cx = v2_tab[idx].x;
        cy = v2_tab[idx].y;
        area = (bx - ax) * (cy - ay) - (by - ay) * (cx - ax);
        if (area == 0) begin
            return;
        end
        left   = clamp_to_view(min_of3(ax, bx, cx));
        right  = clamp_to_view(max_of3(ax, bx, cx));
        top    = clamp_to_view(min_of3(ay, by, cy));
        bottom = clamp_to_view(max_of3(ay, by, cy));
        total_pixels += (right - left + 1) * (bottom - top + 1);
        for (y = top; y <= bottom; y++) begin
            for (x = left; x <= right; x++) begin
                px = 2 * x + 1;
                py = 2 * y + 1;
                w0 = side_of_edge(2 * ax, 2 * ay, 2 * bx, 2 * by, px, py);
                w1 = side_of_edge(2 * bx, 2 * by, 2 * cx, 2 * cy, px, py);
                w2 = side_of_edge(2 * cx, 2 * cy, 2 * ax, 2 * ay, px, py);
                zi = plane_tab[idx].z0 + plane_tab[idx].dzdx * x + plane_tab[idx].dzdy * y;
                f.pixel.x = 6'(x);
                f.pixel.y = 6'(y);
                // Either winding is accepted; the sign of the area picks the inside.
                if (area > 0) begin
                    f.covered = (w0 >= 0) && (w1 >= 0) && (w2 >= 0);
                end else begin
                    f.covered = (w0 <= 0) && (w1 <= 0) && (w2 <= 0);
                end
                f.depth = zi[15:0];
                f.tag   = tag_tab[idx];
                f.last  = (x == right) && (y == bottom);
                exp_q.push_back(f);
                exp_idx_q.push_back(idx);
            end
        end
    endtask

    // Called 1 ns after a rising edge, returns 1 ns after the accepting edge.
    task automatic send_triangle(input int idx);
        bit taken;
        tri_valid = 1'b1;
        tri_v0    = v0_tab[idx];
        tri_v1    = v1_tab[idx];
        tri_v2    = v2_tab[idx];
        tri_plane = plane_tab[idx];
        tri_tag   = tag_tab[idx];
        taken     = 1'b0;
        while (!taken) begin
            taken = tri_ready;
            @(posedge clk);
            #1;
        end
        tri_valid = 1'b0;
    endtask

    task automatic compare_field(input string test, input string field,
                                 input int exp_v, input int act_v);
        assert (exp_v == act_v) else begin
            errors++;
            $display("** Error %s %s: expected %0h, actual %0h", test, field, exp_v, act_v);
        end
    endtask

    task automatic check_fragment(input fragment_t got);
        fragment_t want;
        string     test;
        received++;
        assert (exp_q.size() > 0) else begin
            errors++;
            $display("Fragment at (%0d,%0d) arrived after all expected fragments",
                     got.pixel.x, got.pixel.y);
        end
        if (exp_q.size() == 0) begin
            return;
        end
        want = exp_q.pop_front();
        test = $sformatf("%s (%0d,%0d)", name_tab[exp_idx_q.pop_front()],
                         want.pixel.x, want.pixel.y);
        compare_field(test, "x", want.pixel.x, got.pixel.x);
        compare_field(test, "y", want.pixel.y, got.pixel.y);
        compare_field(test, "covered", want.covered, got.covered);
        compare_field(test, "depth", want.depth, got.depth);
        compare_field(test, "tag", want.tag, got.tag);
        compare_field(test, "last", want.last, got.last);
    endtask

    // Random back-pressure on the fragment output.
    initial begin
        void'($urandom(32'h7aa7));
        frag_ready = 1'b0;
        @(posedge rstn);
        forever begin
            @(posedge clk);
            #1;
            frag_ready = ($urandom % 4) != 0;
        end
    end

    // Both handshake signals are stable at the falling edge.
    initial begin
        forever begin
            @(negedge clk);
            if (rstn && frag_valid && frag_ready) begin
                check_fragment(frag);
            end
        end
    end

    initial begin
        wait (model_done);
        repeat (total_pixels * 8 + MARGIN_CYCLES) @(posedge clk);
        $display("Timeout: only %0d of %0d fragments arrived", received, total_pixels);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        errors       = 0;
        received     = 0;
        total_pixels = 0;
        model_done   = 1'b0;
        rstn         = 1'b0;
        tri_valid    = 1'b0;
        tri_v0       = '0;
        tri_v1       = '0;
        tri_v2       = '0;
        tri_plane    = '0;
        tri_tag      = '0;
        fill_table();
        for (int i = 0; i < NUM_TRI; i++) begin
            add_expected(i);
        end
        model_done = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        rstn = 1'b1;
        assert (tri_ready === 1'b1 && frag_valid === 1'b0) else begin
            errors++;
            $display("After reset tri_ready is not high or frag_valid is not low");
        end
        for (int i = 0; i < NUM_TRI; i++) begin
            send_triangle(i);
        end
        wait (received >= total_pixels);
        // Give any extra fragment time to show up.
        repeat (30) @(posedge clk);
        compare_field("fragment_count", "count", total_pixels, received);
        $display("Fragments checked: %0d, errors: %0d", received, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- list.f
+incdir+verilog
verilog/geom_pkg.sv
verilog/frag_pkg.sv
verilog/triangle_setup.sv
verilog/bbox_scanner.sv
verilog/edge_tester.sv
verilog/depth_interp.sv
verilog/fragment_merge.sv
verilog/rasterizer.sv
tb/rasterizer_checker.sv
tb/rasterizer_tb.sv

//--- Makefile
LOG := sim.log
BIN := obj_dir/Vrasterizer_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module rasterizer_tb
	$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q '\*\* FAIL \*\*' $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
